// File: verification/creg_input.txt
# op name thread field1 field2 field3 expected, numbers in hex
# W R C: field1 index, field2 write data or gap; T: reason pc address; E F A: expected only
R reset_flags_t0 0 4 0 0 4
R reset_flags_t1 1 4 0 0 4
R reset_flags_t2 2 4 0 0 4
R reset_flags_t3 3 4 0 0 4
R reset_reason_t0 0 3 0 0 0
W write_trap_handler 0 1 1000 0 0
W write_tlb_handler 0 7 2000 0 0
R read_trap_handler 2 1 0 0 1000
R read_tlb_handler 3 7 0 0 2000
W write_sp0_t1 1 b cafe0001 0 0
W write_sp1_t1 1 c cafe0002 0 0
R read_sp0_t1 1 b 0 0 cafe0001
R read_sp1_t1 1 c 0 0 cafe0002
W write_asid_t2 2 9 5a 0 0
R read_asid_t2 2 9 0 0 5a
A asid_port_t2 2 0 0 0 5a
W write_trap_pc_t3 3 2 44440000 0 0
R read_trap_pc_t3 3 2 0 0 44440000
W write_subcycle_t3 3 d 7 0 0
R read_subcycle_t3 3 d 0 0 7
R unknown_index 0 1f 0 0 ffffffff
R thread_id_t3 3 0 0 0 3
W user_flags_t1 1 4 3 0 0
T dtlb_trap_t1 1 6 100 beef 2000
F dtlb_flags_t1 1 0 0 0 4
R dtlb_reason_t1 1 3 0 0 6
R dtlb_pc_t1 1 2 0 0 100
R dtlb_address_t1 1 5 0 0 beef
W user_flags_t0 0 4 3 0 0
W level0_sp0_t0 0 b 11 0 0
T syscall_trap_t0 0 4 200 0 1000
F syscall_flags_t0 0 0 0 0 6
W level1_sp0_t0 0 b 22 0 0
T illegal_trap_t0 0 1 300 0 1000
W level2_sp0_t0 0 b 33 0 0
E first_eret_t0 0 0 0 0 300
F first_eret_flags_t0 0 0 0 0 6
R first_eret_sp0_t0 0 b 0 0 22
E second_eret_t0 0 0 0 0 200
F second_eret_flags_t0 0 0 0 0 3
F untouched_flags_t1 1 0 0 0 4
F untouched_flags_t2 2 0 0 0 4
R untouched_sp0_t1 1 b 0 0 cafe0001
A untouched_asid_t2 2 0 0 0 5a
C cycle_count_rises 0 6 10 0 0

// File: compile.f
source/creg_pkg.sv
source/host_request_port.sv
source/trap_event_port.sv
source/control_registers.sv
source/redirect_unit.sv
source/creg_subsystem.sv
verification/creg_subsystem_tb.sv

// File: Makefile
TOOL = verilator
TOP = creg_subsystem_tb
FILELIST = compile.f
FLAGS = --binary --timing --top-module $(TOP) -Mdir obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/creg_subsystem_tb.sv
// Control register subsystem testbench
// Replays host accesses and trap events from a data file and checks the results
`timescale 1ns/100ps

module creg_subsystem_tb
	import creg_pkg::*;
	();

	localparam int ack_timeout = 40;

	logic clk;
	logic reset;
	logic host_req;
	logic host_write;
	logic [thread_idx_width-1:0] host_thread;
	logic [creg_index_width-1:0] host_index;
	logic [scalar_width-1:0] host_wdata;
	logic host_ack;
	logic [scalar_width-1:0] host_rdata;
	logic event_req;
	logic event_eret;
	logic [thread_idx_width-1:0] event_thread;
	logic [trap_reason_width-1:0] event_reason;
	logic [scalar_width-1:0] event_pc;
	logic [scalar_width-1:0] event_access_addr;
	logic [subcycle_width-1:0] event_subcycle;
	logic event_ack;
	logic redirect_valid;
	logic [thread_idx_width-1:0] redirect_thread;
	logic [scalar_width-1:0] redirect_pc;
	logic [threads_per_core-1:0] mmu_en;
	logic [threads_per_core-1:0] supervisor_en;
	logic [threads_per_core-1:0] interrupt_en;
	logic [asid_width-1:0] current_asid[threads_per_core];
	logic [subcycle_width-1:0] eret_subcycle[threads_per_core];
	int pass_count;
	int fail_count;

	creg_subsystem DUT(.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Result: FAILED");
		$finish;
	endtask

	task automatic wait_host_ack(input logic level);
		int cycles;
		cycles = 0;
		while (host_ack !== level && cycles < ack_timeout)
		begin
			@(posedge clk);
			cycles++;
		end
		if (host_ack !== level)
			abort_on_timeout("host ack");
	endtask

	task automatic wait_event_ack(input logic level);
		int cycles;
		cycles = 0;
		while (event_ack !== level && cycles < ack_timeout)
		begin
			@(posedge clk);
			cycles++;
		end
		if (event_ack !== level)
			abort_on_timeout("event ack");
	endtask

	// The redirect pulse is one cycle wide, so every edge is sampled
	task automatic wait_redirect;
		int cycles;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
		end
		while (redirect_valid !== 1'b1 && cycles < ack_timeout);
		if (redirect_valid !== 1'b1)
			abort_on_timeout("redirect valid");
	endtask

	// One full four-phase register access
	task automatic host_access(input logic write, input logic [thread_idx_width-1:0] thread,
		input logic [creg_index_width-1:0] index, input logic [scalar_width-1:0] wdata,
		output logic [scalar_width-1:0] rdata);
		@(posedge clk);
		host_write <= write;
		host_thread <= thread;
		host_index <= index;
		host_wdata <= wdata;
		host_req <= 1'b1;
		wait_host_ack(1'b1);
		rdata = host_rdata;
		@(posedge clk);
		host_req <= 1'b0;
		wait_host_ack(1'b0);
	endtask

	// One full four-phase trap or eret, returning the redirect PC and thread
	task automatic send_event(input logic eret, input logic [thread_idx_width-1:0] thread,
		input logic [trap_reason_width-1:0] reason, input logic [scalar_width-1:0] pc,
		input logic [scalar_width-1:0] addr, output logic [scalar_width-1:0] target,
		output logic [thread_idx_width-1:0] target_thread);
		@(posedge clk);
		event_eret <= eret;
		event_thread <= thread;
		event_reason <= reason;
		event_pc <= pc;
		event_access_addr <= addr;
		event_subcycle <= '0;
		event_req <= 1'b1;
		wait_redirect();
		target = redirect_pc;
		target_thread = redirect_thread;
		wait_event_ack(1'b1);
		@(posedge clk);
		event_req <= 1'b0;
		wait_event_ack(1'b0);
	endtask

	function automatic creg_value_u flags_of(input logic [thread_idx_width-1:0] thread);
		creg_value_u word;
		word.raw = '0;
		word.flags.supervisor_en = supervisor_en[thread];
		word.flags.mmu_en = mmu_en[thread];
		word.flags.interrupt_en = interrupt_en[thread];
		return word;
	endfunction

	task automatic compare_scalar(input string name, input logic [scalar_width-1:0] expected,
		input logic [scalar_width-1:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			fail_count++;
		end
		else
		begin
			$display("[PASS] %s", name);
			pass_count++;
		end
	endtask

	task automatic compare_flags(input string name, input creg_value_u expected,
		input creg_value_u actual);
		if (actual.flags.supervisor_en !== expected.flags.supervisor_en
			|| actual.flags.mmu_en !== expected.flags.mmu_en
			|| actual.flags.interrupt_en !== expected.flags.interrupt_en)
		begin
			$display("[FAIL] %s expected s%b m%b i%b actual s%b m%b i%b", name,
				expected.flags.supervisor_en, expected.flags.mmu_en,
				expected.flags.interrupt_en, actual.flags.supervisor_en,
				actual.flags.mmu_en, actual.flags.interrupt_en);
			fail_count++;
		end
		else
		begin
			$display("[PASS] %s", name);
			pass_count++;
		end
	endtask

	task automatic compare_asid(input string name, input logic [asid_width-1:0] expected,
		input logic [asid_width-1:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			fail_count++;
		end
		else
		begin
			$display("[PASS] %s", name);
			pass_count++;
		end
	endtask

	task automatic compare_subcycle(input string name,
		input logic [subcycle_width-1:0] expected,
		input logic [subcycle_width-1:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			fail_count++;
		end
		else
		begin
			$display("[PASS] %s", name);
			pass_count++;
		end
	endtask

	task automatic compare_thread(input string name,
		input logic [thread_idx_width-1:0] expected,
		input logic [thread_idx_width-1:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			fail_count++;
		end
		else
		begin
			$display("[PASS] %s", name);
			pass_count++;
		end
	endtask

	initial
	begin
		int fd;
		int fields;
		string line;
		string op;
		string name;
		logic [31:0] f_thread;
		logic [31:0] f_a;
		logic [31:0] f_b;
		logic [31:0] f_c;
		logic [31:0] f_expected;
		logic [scalar_width-1:0] value;
		logic [scalar_width-1:0] first_count;
		logic [thread_idx_width-1:0] redirected_thread;
		creg_value_u expected_flags;

		pass_count = 0;
		fail_count = 0;
		reset <= 1'b1;
		host_req <= 1'b0;
		host_write <= 1'b0;
		host_thread <= '0;
		host_index <= '0;
		host_wdata <= '0;
		event_req <= 1'b0;
		event_eret <= 1'b0;
		event_thread <= '0;
		event_reason <= '0;
		event_pc <= '0;
		event_access_addr <= '0;
		event_subcycle <= '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		fd = $fopen("verification/creg_input.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file verification/creg_input.txt");
			fail_count++;
		end

		while (fd != 0 && $fgets(line, fd) != 0)
		begin
			fields = $sscanf(line, "%s %s %h %h %h %h %h", op, name, f_thread,
				f_a, f_b, f_c, f_expected);
			// Skip comments and blank lines
			if (fields == 7 && op != "#")
			begin
				if (op == "W")
				begin
					host_access(1'b1, f_thread[thread_idx_width-1:0],
						f_a[creg_index_width-1:0], f_b, value);
					$display("[DONE] %s write acknowledged", name);
				end
				else if (op == "R")
				begin
					host_access(1'b0, f_thread[thread_idx_width-1:0],
						f_a[creg_index_width-1:0], '0, value);
					compare_scalar(name, f_expected, value);
					// The saved subcycle is also exported per thread
					if (f_a[creg_index_width-1:0] == cr_subcycle)
						compare_subcycle({name, "_port"}, f_expected[subcycle_width-1:0],
							eret_subcycle[f_thread[thread_idx_width-1:0]]);
				end
				else if (op == "T" || op == "E")
				begin
					send_event(op == "E", f_thread[thread_idx_width-1:0],
						f_a[trap_reason_width-1:0], f_b, f_c, value, redirected_thread);
					compare_scalar(name, f_expected, value);
					compare_thread({name, "_thread"}, f_thread[thread_idx_width-1:0],
						redirected_thread);
				end
				else if (op == "F")
				begin
					expected_flags.raw = f_expected;
					compare_flags(name, expected_flags,
						flags_of(f_thread[thread_idx_width-1:0]));
				end
				else if (op == "A")
				begin
					compare_asid(name, f_expected[asid_width-1:0],
						current_asid[f_thread[thread_idx_width-1:0]]);
				end
				else if (op == "C")
				begin
					// Two reads of the counter, the second one later
					host_access(1'b0, f_thread[thread_idx_width-1:0],
						f_a[creg_index_width-1:0], '0, first_count);
					repeat (f_b) @(posedge clk);
					host_access(1'b0, f_thread[thread_idx_width-1:0],
						f_a[creg_index_width-1:0], '0, value);
					if (value > first_count)
					begin
						$display("[PASS] %s", name);
						pass_count++;
					end
					else
					begin
						$display("[FAIL] %s counter did not advance, first %h then %h",
							name, first_count, value);
						fail_count++;
					end
				end
				else
				begin
					$display("Unknown operation %s in test %s", op, name);
					fail_count++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end
endmodule

// File: source/creg_subsystem.sv
// Control register subsystem
// Host and event ports, the register file and the fetch redirect unit
`timescale 1ns/100ps

module creg_subsystem
	import creg_pkg::*;
	(input clk,
	input reset,

	// Host register access
	input host_req,
	input host_write,
	input [thread_idx_width-1:0] host_thread,
	input [creg_index_width-1:0] host_index,
	input [scalar_width-1:0] host_wdata,
	output logic host_ack,
	output logic [scalar_width-1:0] host_rdata,

	// Trap and eret events
	input event_req,
	input event_eret,
	input [thread_idx_width-1:0] event_thread,
	input [trap_reason_width-1:0] event_reason,
	input [scalar_width-1:0] event_pc,
	input [scalar_width-1:0] event_access_addr,
	input [subcycle_width-1:0] event_subcycle,
	output logic event_ack,

	// Fetch redirect
	output logic redirect_valid,
	output logic [thread_idx_width-1:0] redirect_thread,
	output logic [scalar_width-1:0] redirect_pc,

	// Per-thread modes
	output logic [threads_per_core-1:0] mmu_en,
	output logic [threads_per_core-1:0] supervisor_en,
	output logic [threads_per_core-1:0] interrupt_en,
	output logic [asid_width-1:0] current_asid[threads_per_core],
	output logic [subcycle_width-1:0] eret_subcycle[threads_per_core]);

	logic creg_read_en;
	logic creg_write_en;
	logic [thread_idx_width-1:0] creg_thread;
	logic [creg_index_width-1:0] creg_index;
	logic [scalar_width-1:0] creg_wdata;
	logic [scalar_width-1:0] creg_rdata;
	logic trap;
	logic eret;
	logic [thread_idx_width-1:0] trap_thread;
	logic [trap_reason_width-1:0] trap_reason;
	logic [scalar_width-1:0] trap_pc;
	logic [scalar_width-1:0] trap_access_addr;
	logic [subcycle_width-1:0] trap_subcycle;
	logic [scalar_width-1:0] trap_handler;
	logic [scalar_width-1:0] tlb_miss_handler;
	logic [scalar_width-1:0] eret_address[threads_per_core];

	host_request_port host_request_port(.*);

	trap_event_port trap_event_port(.*);

	control_registers control_registers(.*);

	redirect_unit redirect_unit(.*);
endmodule

// File: source/redirect_unit.sv
// Redirect unit
// Turns each trap or eret into a registered fetch redirect
`timescale 1ns/100ps

module redirect_unit
	import creg_pkg::*;
	(input clk,
	input reset,
	input trap,
	input eret,
	input [thread_idx_width-1:0] trap_thread,
	input [trap_reason_width-1:0] trap_reason,
	input [scalar_width-1:0] trap_handler,
	input [scalar_width-1:0] tlb_miss_handler,
	input [scalar_width-1:0] eret_address[threads_per_core],
	output logic redirect_valid,
	output logic [thread_idx_width-1:0] redirect_thread,
	output logic [scalar_width-1:0] redirect_pc);

	logic tlb_miss;
	logic [scalar_width-1:0] target_pc;

	assign tlb_miss = trap_reason == tr_itlb_miss || trap_reason == tr_dtlb_miss;

	// Eret address is sampled before the register file pops it
	assign target_pc = trap ? (tlb_miss ? tlb_miss_handler : trap_handler)
		: eret_address[trap_thread];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			redirect_valid <= 1'b0;
		else
			redirect_valid <= trap || eret;
	end

	always_ff @(posedge clk)
	begin
		if (trap || eret)
		begin
			redirect_thread <= trap_thread;
			redirect_pc <= target_pc;
		end
	end
endmodule

// File: source/control_registers.sv
// Control register file
// Per-thread mode flags and trap state with a two-level save stack,
// global handler addresses and a cycle counter
`timescale 1ns/100ps

module control_registers
	import creg_pkg::*;
	(input clk,
	input reset,

	// Register access from the host port
	input creg_read_en,
	input creg_write_en,
	input [thread_idx_width-1:0] creg_thread,
	input [creg_index_width-1:0] creg_index,
	input [scalar_width-1:0] creg_wdata,
	output logic [scalar_width-1:0] creg_rdata,

	// Trap and eret events
	input trap,
	input eret,
	input [thread_idx_width-1:0] trap_thread,
	input [trap_reason_width-1:0] trap_reason,
	input [scalar_width-1:0] trap_pc,
	input [scalar_width-1:0] trap_access_addr,
	input [subcycle_width-1:0] trap_subcycle,

	// Per-thread state
	output logic [scalar_width-1:0] eret_address[threads_per_core],
	output logic [threads_per_core-1:0] mmu_en,
	output logic [threads_per_core-1:0] supervisor_en,
	output logic [threads_per_core-1:0] interrupt_en,
	output logic [asid_width-1:0] current_asid[threads_per_core],
	output logic [subcycle_width-1:0] eret_subcycle[threads_per_core],

	// Global handlers
	output logic [scalar_width-1:0] trap_handler,
	output logic [scalar_width-1:0] tlb_miss_handler);

	// Level 0 is the current trap, level 1 the one it interrupted
	logic [2:0] saved_flags[2][threads_per_core];
	logic [trap_reason_width-1:0] saved_reason[2][threads_per_core];
	logic [scalar_width-1:0] saved_pc[2][threads_per_core];
	logic [subcycle_width-1:0] saved_subcycle[2][threads_per_core];
	logic [scalar_width-1:0] saved_access_addr[2][threads_per_core];
	logic [scalar_width-1:0] scratchpad0[2][threads_per_core];
	logic [scalar_width-1:0] scratchpad1[2][threads_per_core];
	logic [scalar_width-1:0] cycle_count;
	logic trap_is_tlb_miss;
	creg_value_u write_word;
	creg_value_u read_word;

	assign eret_address = saved_pc[0];
	assign eret_subcycle = saved_subcycle[0];
	assign write_word.raw = creg_wdata;
	assign trap_is_tlb_miss = trap_reason == tr_itlb_miss || trap_reason == tr_dtlb_miss;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < threads_per_core; i++)
			begin
				// Threads come up in supervisor mode
				supervisor_en[i] <= 1'b1;
				mmu_en[i] <= 1'b0;
				interrupt_en[i] <= 1'b0;
				current_asid[i] <= '0;
				for (int lvl = 0; lvl < 2; lvl++)
				begin
					saved_flags[lvl][i] <= 3'b100;
					saved_reason[lvl][i] <= tr_reset;
					saved_pc[lvl][i] <= '0;
					saved_subcycle[lvl][i] <= '0;
				end
			end
			trap_handler <= '0;
			tlb_miss_handler <= '0;
			cycle_count <= '0;
		end
		else
		begin
			cycle_count <= cycle_count + 1;

			if (trap)
			begin
				// Push, then record the new trap
				saved_flags[1][trap_thread] <= saved_flags[0][trap_thread];
				saved_reason[1][trap_thread] <= saved_reason[0][trap_thread];
				saved_pc[1][trap_thread] <= saved_pc[0][trap_thread];
				saved_subcycle[1][trap_thread] <= saved_subcycle[0][trap_thread];
				saved_flags[0][trap_thread] <= {supervisor_en[trap_thread],
					mmu_en[trap_thread], interrupt_en[trap_thread]};
				saved_reason[0][trap_thread] <= trap_reason;
				saved_pc[0][trap_thread] <= trap_pc;
				saved_subcycle[0][trap_thread] <= trap_subcycle;
				supervisor_en[trap_thread] <= 1'b1;
				interrupt_en[trap_thread] <= 1'b0;
				if (trap_is_tlb_miss)
					mmu_en[trap_thread] <= 1'b0;
			end
			else if (eret)
			begin
				// Restore flags and pop
				{supervisor_en[trap_thread], mmu_en[trap_thread], interrupt_en[trap_thread]}
					<= saved_flags[0][trap_thread];
				saved_flags[0][trap_thread] <= saved_flags[1][trap_thread];
				saved_reason[0][trap_thread] <= saved_reason[1][trap_thread];
				saved_pc[0][trap_thread] <= saved_pc[1][trap_thread];
				saved_subcycle[0][trap_thread] <= saved_subcycle[1][trap_thread];
			end

			// Writes come last so they override the event on shared fields
			if (creg_write_en)
			begin
				case (creg_index)
					cr_flags:
					begin
						supervisor_en[creg_thread] <= write_word.flags.supervisor_en;
						mmu_en[creg_thread] <= write_word.flags.mmu_en;
						interrupt_en[creg_thread] <= write_word.flags.interrupt_en;
					end

					cr_saved_flags:
					begin
						saved_flags[0][creg_thread] <= {write_word.flags.supervisor_en,
							write_word.flags.mmu_en, write_word.flags.interrupt_en};
					end

					cr_trap_pc: saved_pc[0][creg_thread] <= creg_wdata;
					cr_trap_handler: trap_handler <= creg_wdata;
					cr_tlb_miss_handler: tlb_miss_handler <= creg_wdata;
					cr_subcycle: saved_subcycle[0][creg_thread] <= creg_wdata[subcycle_width-1:0];
					cr_current_asid: current_asid[creg_thread] <= creg_wdata[asid_width-1:0];
					default:
						;
				endcase
			end
		end
	end

	// Access addresses, scratchpads and read data
	always_ff @(posedge clk)
	begin
		if (trap)
		begin
			saved_access_addr[1][trap_thread] <= saved_access_addr[0][trap_thread];
			saved_access_addr[0][trap_thread] <= trap_access_addr;
			scratchpad0[1][trap_thread] <= scratchpad0[0][trap_thread];
			scratchpad1[1][trap_thread] <= scratchpad1[0][trap_thread];
		end
		else if (eret)
		begin
			saved_access_addr[0][trap_thread] <= saved_access_addr[1][trap_thread];
			scratchpad0[0][trap_thread] <= scratchpad0[1][trap_thread];
			scratchpad1[0][trap_thread] <= scratchpad1[1][trap_thread];
		end

		if (creg_write_en && creg_index == cr_scratchpad0)
			scratchpad0[0][creg_thread] <= creg_wdata;

		if (creg_write_en && creg_index == cr_scratchpad1)
			scratchpad1[0][creg_thread] <= creg_wdata;

		if (creg_read_en)
			creg_rdata <= read_word.raw;
	end

	// Read mux
	always_comb
	begin
		read_word.raw = '0;
		case (creg_index)
			cr_flags:
			begin
				read_word.flags.supervisor_en = supervisor_en[creg_thread];
				read_word.flags.mmu_en = mmu_en[creg_thread];
				read_word.flags.interrupt_en = interrupt_en[creg_thread];
			end

			cr_saved_flags:
			begin
				{read_word.flags.supervisor_en, read_word.flags.mmu_en,
					read_word.flags.interrupt_en} = saved_flags[0][creg_thread];
			end

			cr_thread_id: read_word.raw = scalar_width'({core_id, creg_thread});
			cr_trap_pc: read_word.raw = saved_pc[0][creg_thread];
			cr_trap_reason: read_word.raw = scalar_width'(saved_reason[0][creg_thread]);
			cr_trap_handler: read_word.raw = trap_handler;
			cr_trap_address: read_word.raw = saved_access_addr[0][creg_thread];
			cr_tlb_miss_handler: read_word.raw = tlb_miss_handler;
			cr_cycle_count: read_word.raw = cycle_count;
			cr_scratchpad0: read_word.raw = scratchpad0[0][creg_thread];
			cr_scratchpad1: read_word.raw = scratchpad1[0][creg_thread];
			cr_subcycle: read_word.raw = scalar_width'(saved_subcycle[0][creg_thread]);
			cr_current_asid: read_word.raw = scalar_width'(current_asid[creg_thread]);
			default: read_word.raw = '1;
		endcase
	end
endmodule

// File: source/trap_event_port.sv
// Trap event port
// Four-phase req/ack event input; each cycle yields one trap or eret pulse
`timescale 1ns/100ps

module trap_event_port
	import creg_pkg::*;
	(input clk,
	input reset,

	// Event source side
	input event_req,
	input event_eret,
	input [thread_idx_width-1:0] event_thread,
	input [trap_reason_width-1:0] event_reason,
	input [scalar_width-1:0] event_pc,
	input [scalar_width-1:0] event_access_addr,
	input [subcycle_width-1:0] event_subcycle,
	output logic event_ack,

	// To register file and redirect unit
	output logic trap,
	output logic eret,
	output logic [thread_idx_width-1:0] trap_thread,
	output logic [trap_reason_width-1:0] trap_reason,
	output logic [scalar_width-1:0] trap_pc,
	output logic [scalar_width-1:0] trap_access_addr,
	output logic [subcycle_width-1:0] trap_subcycle);

	logic accept;

	// Idle means no pulse in flight and ack already released
	assign accept = event_req && !event_ack && !trap && !eret;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			trap <= 1'b0;
			eret <= 1'b0;
			event_ack <= 1'b0;
		end
		else if (trap || eret)
		begin
			trap <= 1'b0;
			eret <= 1'b0;
			event_ack <= 1'b1;
		end
		else if (event_ack)
		begin
			if (!event_req)
				event_ack <= 1'b0;
		end
		else if (event_req)
		begin
			trap <= !event_eret;
			eret <= event_eret;
		end
	end

	// Event fields held from the accepting edge
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			trap_thread <= event_thread;
			trap_reason <= event_reason;
			trap_pc <= event_pc;
			trap_access_addr <= event_access_addr;
			trap_subcycle <= event_subcycle;
		end
	end
endmodule

// File: source/host_request_port.sv
// Host request port
// Four-phase req/ack register access; issues one read or write per request
`timescale 1ns/100ps

module host_request_port
	import creg_pkg::*;
	(input clk,
	input reset,

	// Host side
	input host_req,
	input host_write,
	input [thread_idx_width-1:0] host_thread,
	input [creg_index_width-1:0] host_index,
	input [scalar_width-1:0] host_wdata,
	output logic host_ack,
	output logic [scalar_width-1:0] host_rdata,

	// Register file side
	input [scalar_width-1:0] creg_rdata,
	output logic creg_read_en,
	output logic creg_write_en,
	output logic [thread_idx_width-1:0] creg_thread,
	output logic [creg_index_width-1:0] creg_index,
	output logic [scalar_width-1:0] creg_wdata);

	logic [1:0] state;

	// Request fields are stable while req is high
	assign creg_thread = host_thread;
	assign creg_index = host_index;
	assign creg_wdata = host_wdata;

	// One access, only in the issue state
	assign creg_read_en = state == hs_issue && !host_write;
	assign creg_write_en = state == hs_issue && host_write;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= hs_idle;
			host_ack <= 1'b0;
		end
		else
		begin
			case (state)
				hs_idle:
				begin
					if (host_req)
						state <= hs_issue;
				end

				hs_issue:
					state <= hs_respond;

				hs_respond:
				begin
					host_ack <= 1'b1;
					state <= hs_wait_release;
				end

				default:
				begin
					// Hold ack until the host drops req
					if (!host_req)
					begin
						host_ack <= 1'b0;
						state <= hs_idle;
					end
				end
			endcase
		end
	end

	// Read data captured together with ack
	always_ff @(posedge clk)
	begin
		if (state == hs_respond && !host_write)
			host_rdata <= creg_rdata;
	end
endmodule

// File: source/creg_pkg.sv
// Control register package
// Widths, register index codes, trap reasons and the decoded register word
package creg_pkg;
	localparam int threads_per_core = 4;
	localparam int thread_idx_width = 2;
	localparam int scalar_width = 32;
	localparam int asid_width = 8;
	localparam int subcycle_width = 4;
	localparam int creg_index_width = 5;
	localparam int trap_reason_width = 4;

	// Reported in the upper bits of the thread id register
	localparam logic [3:0] core_id = 4'd0;

	// Control register index codes
	localparam logic [creg_index_width-1:0] cr_thread_id = 5'd0;
	localparam logic [creg_index_width-1:0] cr_trap_handler = 5'd1;
	localparam logic [creg_index_width-1:0] cr_trap_pc = 5'd2;
	localparam logic [creg_index_width-1:0] cr_trap_reason = 5'd3;
	localparam logic [creg_index_width-1:0] cr_flags = 5'd4;
	localparam logic [creg_index_width-1:0] cr_trap_address = 5'd5;
	localparam logic [creg_index_width-1:0] cr_cycle_count = 5'd6;
	localparam logic [creg_index_width-1:0] cr_tlb_miss_handler = 5'd7;
	localparam logic [creg_index_width-1:0] cr_saved_flags = 5'd8;
	localparam logic [creg_index_width-1:0] cr_current_asid = 5'd9;
	localparam logic [creg_index_width-1:0] cr_scratchpad0 = 5'd11;
	localparam logic [creg_index_width-1:0] cr_scratchpad1 = 5'd12;
	localparam logic [creg_index_width-1:0] cr_subcycle = 5'd13;

	// Trap reasons
	localparam logic [trap_reason_width-1:0] tr_reset = 4'd0;
	localparam logic [trap_reason_width-1:0] tr_illegal_instruction = 4'd1;
	localparam logic [trap_reason_width-1:0] tr_privileged_op = 4'd2;
	localparam logic [trap_reason_width-1:0] tr_interrupt = 4'd3;
	localparam logic [trap_reason_width-1:0] tr_syscall = 4'd4;
	localparam logic [trap_reason_width-1:0] tr_itlb_miss = 4'd5;
	localparam logic [trap_reason_width-1:0] tr_dtlb_miss = 4'd6;

	// Host port FSM states
	localparam logic [1:0] hs_idle = 2'd0;
	localparam logic [1:0] hs_issue = 2'd1;
	localparam logic [1:0] hs_respond = 2'd2;
	localparam logic [1:0] hs_wait_release = 2'd3;

	// One register word, seen raw or as the flags layout
	typedef union packed
	{
		logic [scalar_width-1:0] raw;
		struct packed
		{
			logic [scalar_width-4:0] padding;
			logic supervisor_en;
			logic mmu_en;
			logic interrupt_en;
		} flags;
	} creg_value_u;
endpackage
